// File: source/cw_route_pkg.sv
`default_nettype none

package cw_route_pkg;

	// how the enabled external trigger sources are merged
	typedef enum logic [1:0] {
		COMB_OR   = 2'd0, // any enabled source high
		COMB_AND  = 2'd1, // all enabled sources high
		COMB_NAND = 2'd2, // inverted and
		COMB_OFF  = 2'd3  // combined trigger held low
	} comb_mode_e;

	// which block feeds the capture trigger
	typedef enum logic [2:0] {
		TRIG_EDGE       = 3'd0, // combined external trigger
		TRIG_ADVIO      = 3'd1, // advanced io pattern
		TRIG_ANAPATTERN = 3'd2, // analog pattern match
		TRIG_DECODEDIO  = 3'd3  // decoded io trigger
	} trig_module_e;

	// one tristate pin split into value and enable
	typedef struct packed {
		logic value; // level driven when enabled
		logic oe;    // output enable, released when low
	} pin_drive_t;

endpackage

`default_nettype wire

// File: source/cw_reg_map_pkg.sv
`default_nettype none

package cw_reg_map_pkg;
	import cw_route_pkg::*;

	typedef logic [5:0] addr_t; // host register address

	localparam addr_t ADDR_TRIGSRC = 6'd39; // external trigger sources
	localparam addr_t ADDR_TRIGMOD = 6'd40; // trigger module select
	localparam addr_t ADDR_IOROUTE = 6'd55; // target io routing

	localparam int IOROUTE_BYTES = 8; // length of the routing register

	typedef struct packed {
		comb_mode_e mode;  // merge rule for enabled sources
		logic       rear4; // rear io line 4
		logic       rear3; // rear io line 3
		logic       rear2; // rear io line 2
		logic       rear1; // rear io line 1
		logic       fpb;   // front panel b
		logic       fpa;   // front panel a
	} trigsrc_t;

	typedef struct packed {
		logic [2:0]   unused;
		logic         fpb_drive;   // put trigger out on front panel b
		logic         fpa_drive;   // put trigger out on front panel a
		trig_module_e trig_module; // trigger source select
	} trigmod_t;

	typedef struct packed {
		logic manual_en;    // drive the manual level
		logic manual_level;
		logic uart_oc;      // uart tx as open collector
		logic usi_oc;       // usi out as open collector
		logic usi_in;       // pin feeds usi input
		logic usi_out;      // pin carries usi output
		logic rx;           // pin feeds uart rx
		logic tx;           // pin carries uart tx
	} gpio_route_t;

	typedef struct packed {
		logic [4:0] unused;
		logic       fast_start; // skip the pwm soft-start
		logic       power_off;  // target power switched off
		logic       avrprog_en; // connect avr programming lines
	} extra_t;

	typedef struct packed {
		logic [1:0] unused;
		logic       pdic_level;
		logic       pdic_en;
		logic       pdid_level;
		logic       pdid_en;
		logic       nrst_level;
		logic       nrst_en;
	} extra_gpio_t;

	// byte 0 sits at the bottom, gpio[0] is target pin 1
	typedef struct packed {
		logic [7:0]        rsvd7;
		extra_gpio_t       extra_gpio; // byte 6
		extra_t            extra;      // byte 5
		logic [7:0]        rsvd4;      // old glitch output byte
		gpio_route_t [3:0] gpio;       // bytes 0 to 3
	} ioroute_t;

	localparam trigsrc_t TRIGSRC_RESET = '{
		mode:  COMB_OR,
		rear4: 1'b0,
		rear3: 1'b0,
		rear2: 1'b0,
		rear1: 1'b0,
		fpb:   1'b0,
		fpa:   1'b1
	};
	localparam trigmod_t TRIGMOD_RESET = trigmod_t'(8'h00);
	localparam ioroute_t IOROUTE_RESET = ioroute_t'(64'h0000_0000_0000_0201); // pin 1 tx, pin 2 rx

endpackage

`default_nettype wire

// File: source/cw_config_regs.sv
`default_nettype none

module cw_config_regs
	import cw_reg_map_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire addr_t  reg_address_i,    // register under access
	input  wire  [15:0] reg_bytecnt_i,    // byte index inside a wide register
	input  wire  [7:0]  reg_datai_i,      // write data
	input  wire         reg_read_i,       // read strobe
	input  wire         reg_write_i,      // write strobe
	input  wire         reg_addrvalid_i,  // address phase valid
	input  wire addr_t  reg_hypaddress_i, // address for the length query
	output logic [7:0]  reg_datao_o,      // registered read data
	output logic [15:0] reg_hyplen_o,     // transfer length of hypaddress
	output trigsrc_t    trigsrc_o,
	output trigmod_t    trigmod_o,
	output ioroute_t    ioroute_o
);

	trigsrc_t                      trigsrc_q;
	trigmod_t                      trigmod_q;
	logic [IOROUTE_BYTES-1:0][7:0] ioroute_q; // routing kept as bytes
	logic [2:0]                    byte_sel;
	logic                          byte_ok;
	logic                          addr_mapped;
	logic [7:0]                    rd_mux;
	logic [7:0]                    rd_data_q;
	logic                          rd_valid_q;

	assign byte_sel = reg_bytecnt_i[2:0];
	assign byte_ok  = reg_bytecnt_i < 16'(IOROUTE_BYTES); // bytes past the end are ignored

	// address decode and read-back select
	always_comb begin
		addr_mapped = 1'b1;
		case (reg_address_i)
			ADDR_TRIGSRC: rd_mux = trigsrc_q;
			ADDR_TRIGMOD: rd_mux = trigmod_q;
			ADDR_IOROUTE: rd_mux = byte_ok ? ioroute_q[byte_sel] : 8'h00;
			default: begin
				rd_mux      = 8'h00;
				addr_mapped = 1'b0; // unknown register reads as zero
			end
		endcase
	end

	// host writes land the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			trigsrc_q <= TRIGSRC_RESET;
			trigmod_q <= TRIGMOD_RESET;
			ioroute_q <= IOROUTE_RESET;
		end else if (reg_write_i) begin
			case (reg_address_i)
				ADDR_TRIGSRC: trigsrc_q <= trigsrc_t'(reg_datai_i);
				ADDR_TRIGMOD: trigmod_q <= trigmod_t'(reg_datai_i);
				ADDR_IOROUTE: begin
					if (byte_ok)
						ioroute_q[byte_sel] <= reg_datai_i; // one byte per bus cycle
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			rd_valid_q <= 1'b0;
		else
			rd_valid_q <= reg_addrvalid_i & addr_mapped; // data valid one cycle later
	end

	always_ff @(posedge clk) begin
		if (reg_read_i)
			rd_data_q <= rd_mux; // capture on the read strobe
	end

	assign reg_datao_o = rd_valid_q ? rd_data_q : 8'h00; // zero unless we own the bus

	// length the host should move for each address
	always_comb begin
		case (reg_hypaddress_i)
			ADDR_TRIGSRC: reg_hyplen_o = 16'd1;
			ADDR_TRIGMOD: reg_hyplen_o = 16'd1;
			ADDR_IOROUTE: reg_hyplen_o = 16'(IOROUTE_BYTES);
			default:      reg_hyplen_o = 16'd0;
		endcase
	end

	assign trigsrc_o = trigsrc_q;
	assign trigmod_o = trigmod_q;
	assign ioroute_o = ioroute_t'(ioroute_q);

endmodule

`default_nettype wire

// File: source/cw_trigger_mux.sv
`default_nettype none

module cw_trigger_mux
	import cw_route_pkg::*, cw_reg_map_pkg::*;
(
	input  wire trigsrc_t  trigsrc_i,           // source enables and merge mode
	input  wire trigmod_t  trigmod_i,           // module select and panel drive
	input  wire            fpa_in_i,            // front panel a level
	input  wire            fpb_in_i,            // front panel b level
	input  wire [3:0]      rear_in_i,           // rear io lines 1 to 4
	input  wire            trigger_advio_i,
	input  wire            trigger_anapattern_i,
	input  wire            trigger_decodedio_i,
	output logic           trigger_o,           // to the capture logic
	output logic           trigger_ext_o,       // merged external trigger
	output pin_drive_t     fpa_o,
	output pin_drive_t     fpb_o
);

	logic [5:0] src_en;
	logic [5:0] src_val;
	logic       trig_or;
	logic       trig_and;
	logic       trig_ext;
	logic       trigger;

	// bit order follows the register layout
	assign src_en = {trigsrc_i.rear4, trigsrc_i.rear3, trigsrc_i.rear2,
			trigsrc_i.rear1, trigsrc_i.fpb, trigsrc_i.fpa};
	assign src_val = {rear_in_i, fpb_in_i, fpa_in_i};

	assign trig_or  = |(src_en & src_val);
	assign trig_and = &(src_val | ~src_en); // disabled sources do not block

	always_comb begin
		case (trigsrc_i.mode)
			COMB_OR:   trig_ext = trig_or;
			COMB_AND:  trig_ext = trig_and;
			COMB_NAND: trig_ext = ~trig_and;
			default:   trig_ext = 1'b0;
		endcase
	end

	always_comb begin
		case (trigmod_i.trig_module)
			TRIG_EDGE:       trigger = trig_ext;
			TRIG_ADVIO:      trigger = trigger_advio_i;
			TRIG_ANAPATTERN: trigger = trigger_anapattern_i;
			TRIG_DECODEDIO:  trigger = trigger_decodedio_i;
			default:         trigger = 1'b0; // spare codes stay quiet
		endcase
	end

	assign trigger_ext_o = trig_ext;
	assign trigger_o     = trigger;

	// panel pins only leave high-z when asked
	assign fpa_o = '{value: trigger & trigmod_i.fpa_drive, oe: trigmod_i.fpa_drive};
	assign fpb_o = '{value: trigger & trigmod_i.fpb_drive, oe: trigmod_i.fpb_drive};

endmodule

`default_nettype wire

// File: source/cw_target_io.sv
`default_nettype none

module cw_target_io
	import cw_route_pkg::*, cw_reg_map_pkg::*;
(
	input  wire gpio_route_t [3:0] route_i,       // per pin routing bytes
	input  wire extra_gpio_t       extra_gpio_i,  // manual nrst/pdid/pdic
	input  wire                    power_off_i,   // target unpowered
	input  wire                    uart_tx_i,
	input  wire                    usi_out_i,
	input  wire [3:0]              targetio_in_i, // levels seen on the pins
	output pin_drive_t [3:0]       targetio_o,
	output logic                   uart_rx_o,
	output logic                   usi_in_o,
	output pin_drive_t             nrst_o,
	output pin_drive_t             pdid_o,
	output pin_drive_t             pdic_o
);

	for (genvar i = 0; i < 4; i++) begin : g_pin
		localparam bit HAS_USI = (i < 3);  // pin 4 has no usi
		localparam bit HAS_OC  = (i == 2); // open collector only on pin 3

		pin_drive_t drv;

		// first set bit wins, top of the chain first
		always_comb begin
			drv = '{value: 1'b0, oe: 1'b0};
			if (power_off_i) begin
				drv = '{value: 1'b0, oe: 1'b0}; // never back-power the target
			end else if (route_i[i].tx) begin
				drv = '{value: uart_tx_i, oe: 1'b1};
			end else if (HAS_USI && route_i[i].usi_out) begin
				drv = '{value: usi_out_i, oe: 1'b1};
			end else if (HAS_OC && route_i[i].usi_oc) begin
				drv = '{value: 1'b0, oe: ~usi_out_i}; // pull low or let go
			end else if (HAS_OC && route_i[i].uart_oc) begin
				drv = '{value: 1'b0, oe: ~uart_tx_i};
			end else if (route_i[i].manual_en) begin
				drv = '{value: route_i[i].manual_level, oe: 1'b1};
			end
		end

		assign targetio_o[i] = drv;
	end

	// lowest numbered pin takes the input, idle high
	always_comb begin
		uart_rx_o = 1'b1;
		for (int i = 3; i >= 0; i--) begin
			if (route_i[i].rx)
				uart_rx_o = targetio_in_i[i];
		end
	end

	always_comb begin
		usi_in_o = 1'b1;
		for (int i = 2; i >= 0; i--) begin // usi on pins 1 to 3
			if (route_i[i].usi_in)
				usi_in_o = targetio_in_i[i];
		end
	end

	assign nrst_o = '{value: extra_gpio_i.nrst_level, oe: extra_gpio_i.nrst_en};
	assign pdid_o = '{value: extra_gpio_i.pdid_level, oe: extra_gpio_i.pdid_en};
	assign pdic_o = '{value: extra_gpio_i.pdic_level, oe: extra_gpio_i.pdic_en};

endmodule

`default_nettype wire

// File: source/cw_target_power.sv
`default_nettype none

module cw_target_power
	import cw_reg_map_pkg::*;
#(
	parameter int PWM_BITS     = 11,   // soft-start period is 2^PWM_BITS clocks
	parameter int PWM_ON_COUNT = 1400, // counts held off at the start of each period
	parameter int SOFT_PERIODS = 16383 // periods in one soft-start
) (
	input  wire         clk,
	input  wire         reset,
	input  wire extra_t extra_i,
	output logic        power_off_o,       // registered power-off request
	output logic        targetpower_off_o, // drives the power switch
	output logic        enable_avrprog_o
);

	localparam int PERIOD_W = $clog2(SOFT_PERIODS + 1);

	typedef enum logic [1:0] {
		SOFT_IDLE, // steady on or off
		SOFT_WAIT, // power on seen, waiting for a period boundary
		SOFT_RUN   // switching the supply on gradually
	} soft_state_e;

	soft_state_e         state_q;
	logic                power_off_q;
	logic                power_off_prev_q;
	logic [PWM_BITS-1:0] pwm_cnt_q;
	logic [PERIOD_W-1:0] period_cnt_q;
	logic                power_fall;
	logic                pwm_last;
	logic                pwm_high;

	always_ff @(posedge clk) begin
		if (reset) begin
			power_off_q      <= 1'b0;
			power_off_prev_q <= 1'b0;
			pwm_cnt_q        <= '0;
		end else begin
			power_off_q      <= extra_i.power_off;
			power_off_prev_q <= power_off_q;
			pwm_cnt_q        <= pwm_cnt_q + 1'b1; // free running
		end
	end

	assign power_fall = power_off_prev_q & ~power_off_q;   // power just requested on
	assign pwm_last   = pwm_cnt_q == {PWM_BITS{1'b1}};      // next clock starts a period
	assign pwm_high   = pwm_cnt_q < PWM_BITS'(PWM_ON_COUNT); // off slice of the period

	always_ff @(posedge clk) begin
		if (reset || power_off_q) begin
			state_q      <= SOFT_IDLE; // power off aborts at once
			period_cnt_q <= '0;
		end else begin
			case (state_q)
				SOFT_IDLE: begin
					if (power_fall)
						state_q <= SOFT_WAIT;
				end
				SOFT_WAIT: begin
					if (pwm_last) begin
						state_q      <= SOFT_RUN;
						period_cnt_q <= PERIOD_W'(1);
					end
				end
				SOFT_RUN: begin
					if (pwm_last) begin
						if (period_cnt_q == PERIOD_W'(SOFT_PERIODS))
							state_q <= SOFT_IDLE; // fully on from here
						else
							period_cnt_q <= period_cnt_q + 1'b1;
					end
				end
				default: state_q <= SOFT_IDLE;
			endcase
		end
	end

	assign targetpower_off_o = power_off_q |
			((state_q == SOFT_RUN) & ~extra_i.fast_start & pwm_high);
	assign power_off_o      = power_off_q;
	assign enable_avrprog_o = extra_i.avrprog_en;

endmodule

`default_nettype wire

// File: source/cw_aux_io.sv
`default_nettype none

module cw_aux_io
	import cw_route_pkg::*, cw_reg_map_pkg::*;
#(
	parameter int PWM_BITS     = 11,
	parameter int PWM_ON_COUNT = 1400,
	parameter int SOFT_PERIODS = 16383
) (
	input  wire              clk,
	input  wire              reset,
	// host register bus
	input  wire addr_t       reg_address_i,
	input  wire  [15:0]      reg_bytecnt_i,
	input  wire  [7:0]       reg_datai_i,
	input  wire              reg_read_i,
	input  wire              reg_write_i,
	input  wire              reg_addrvalid_i,
	input  wire addr_t       reg_hypaddress_i,
	output logic [7:0]       reg_datao_o,
	output logic [15:0]      reg_hyplen_o,
	// trigger sources and outputs
	input  wire              fpa_in_i,
	input  wire              fpb_in_i,
	input  wire  [3:0]       rear_in_i,
	input  wire              trigger_advio_i,
	input  wire              trigger_anapattern_i,
	input  wire              trigger_decodedio_i,
	output logic             trigger_o,
	output logic             trigger_ext_o,
	output pin_drive_t       fpa_o,
	output pin_drive_t       fpb_o,
	// target side
	input  wire              uart_tx_i,
	input  wire              usi_out_i,
	input  wire  [3:0]       targetio_in_i,
	output pin_drive_t [3:0] targetio_o,
	output logic             uart_rx_o,
	output logic             usi_in_o,
	output pin_drive_t       nrst_o,
	output pin_drive_t       pdid_o,
	output pin_drive_t       pdic_o,
	output logic             targetpower_off_o,
	output logic             enable_avrprog_o
);

	trigsrc_t trigsrc;
	trigmod_t trigmod;
	ioroute_t ioroute;
	logic     power_off_q; // from the power block, releases the pins

	cw_config_regs u_config_regs (
		.clk              (clk),
		.reset            (reset),
		.reg_address_i    (reg_address_i),
		.reg_bytecnt_i    (reg_bytecnt_i),
		.reg_datai_i      (reg_datai_i),
		.reg_read_i       (reg_read_i),
		.reg_write_i      (reg_write_i),
		.reg_addrvalid_i  (reg_addrvalid_i),
		.reg_hypaddress_i (reg_hypaddress_i),
		.reg_datao_o      (reg_datao_o),
		.reg_hyplen_o     (reg_hyplen_o),
		.trigsrc_o        (trigsrc),
		.trigmod_o        (trigmod),
		.ioroute_o        (ioroute)
	);

	cw_trigger_mux u_trigger_mux (
		.trigsrc_i            (trigsrc),
		.trigmod_i            (trigmod),
		.fpa_in_i             (fpa_in_i),
		.fpb_in_i             (fpb_in_i),
		.rear_in_i            (rear_in_i),
		.trigger_advio_i      (trigger_advio_i),
		.trigger_anapattern_i (trigger_anapattern_i),
		.trigger_decodedio_i  (trigger_decodedio_i),
		.trigger_o            (trigger_o),
		.trigger_ext_o        (trigger_ext_o),
		.fpa_o                (fpa_o),
		.fpb_o                (fpb_o)
	);

	cw_target_io u_target_io (
		.route_i       (ioroute.gpio),
		.extra_gpio_i  (ioroute.extra_gpio),
		.power_off_i   (power_off_q),
		.uart_tx_i     (uart_tx_i),
		.usi_out_i     (usi_out_i),
		.targetio_in_i (targetio_in_i),
		.targetio_o    (targetio_o),
		.uart_rx_o     (uart_rx_o),
		.usi_in_o      (usi_in_o),
		.nrst_o        (nrst_o),
		.pdid_o        (pdid_o),
		.pdic_o        (pdic_o)
	);

	cw_target_power #(
		.PWM_BITS     (PWM_BITS),
		.PWM_ON_COUNT (PWM_ON_COUNT),
		.SOFT_PERIODS (SOFT_PERIODS)
	) u_target_power (
		.clk               (clk),
		.reset             (reset),
		.extra_i           (ioroute.extra),
		.power_off_o       (power_off_q),
		.targetpower_off_o (targetpower_off_o),
		.enable_avrprog_o  (enable_avrprog_o)
	);

endmodule

`default_nettype wire

// File: sim/cw_aux_io_assertions.sv
`default_nettype none

module cw_aux_io_assertions
	import cw_route_pkg::*, cw_reg_map_pkg::*;
(
	input wire              clk,
	input wire              reset,
	input wire addr_t       reg_address_i,
	input wire              reg_addrvalid_i,
	input wire [7:0]        reg_datao_o,
	input wire [15:0]       reg_hyplen_o,
	input wire              power_off_q,
	input wire pin_drive_t [3:0] targetio_o,
	input wire trigmod_t    trigmod,
	input wire              trigger_o
);

	logic mapped;
	assign mapped = reg_addrvalid_i && (reg_address_i == ADDR_TRIGSRC ||
			reg_address_i == ADDR_TRIGMOD || reg_address_i == ADDR_IOROUTE);

	a_read_quiet: assert property (@(posedge clk) disable iff (reset)
			!$past(mapped) |-> reg_datao_o == 8'h00)
		else $error("read data without a valid mapped address");

	a_pins_released: assert property (@(posedge clk) disable iff (reset)
			power_off_q |-> !(targetio_o[0].oe || targetio_o[1].oe ||
			targetio_o[2].oe || targetio_o[3].oe))
		else $error("target pin driven while unpowered");

	a_hyplen: assert property (@(posedge clk) disable iff (reset)
			reg_hyplen_o == 16'd0 || reg_hyplen_o == 16'd1 || reg_hyplen_o == 16'd8)
		else $error("bad transfer length");

	a_spare_module: assert property (@(posedge clk) disable iff (reset)
			trigmod.trig_module[2] |-> !trigger_o) // codes 4 to 7
		else $error("trigger from an unused module code");

endmodule

bind cw_aux_io cw_aux_io_assertions u_assertions (
	.clk             (clk),
	.reset           (reset),
	.reg_address_i   (reg_address_i),
	.reg_addrvalid_i (reg_addrvalid_i),
	.reg_datao_o     (reg_datao_o),
	.reg_hyplen_o    (reg_hyplen_o),
	.power_off_q     (power_off_q),
	.targetio_o      (targetio_o),
	.trigmod         (trigmod),
	.trigger_o       (trigger_o)
);

`default_nettype wire

// File: sim/cw_aux_io_tb.sv
`default_nettype none

module cw_aux_io_tb
	import cw_route_pkg::*, cw_reg_map_pkg::*;
;
	localparam int PWM_BITS     = 4;
	localparam int PWM_ON_COUNT = 10;
	localparam int SOFT_PERIODS = 3;
	localparam int PERIOD       = 4;
	localparam int REG_ROWS     = 31;
	localparam int IO_ROWS      = 15;
	localparam int TRIG_ITERS   = 64;
	localparam int SOFT_LEN     = (SOFT_PERIODS + 2) << PWM_BITS; // cycles a soft-start may take
	localparam int LIMIT        = ((REG_ROWS + IO_ROWS + TRIG_ITERS) * 20 + 4 * SOFT_LEN) * PERIOD;
	localparam logic [1:0] K_WR = 2'd0, K_RD = 2'd1, K_LEN = 2'd2;

	typedef struct packed {
		logic [1:0]  kind;  // write, read or length query
		logic [5:0]  addr;
		logic [15:0] bytecnt;
		logic [7:0]  data;  // write data or expected value
	} reg_row_t;

	typedef struct packed {
		logic [2:0] byte_i; // ioroute byte written first
		logic [7:0] data;
		logic       tx;
		logic       usi;
		logic [3:0] tin;
		logic [7:0] pins;   // expected {value, oe} of pins 4 to 1
		logic       rx;
		logic       usi_in;
	} io_row_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [5:0] reg_address = '0;
	logic [15:0] reg_bytecnt = '0;
	logic [7:0] reg_datai = '0;
	logic reg_read = 1'b0;
	logic reg_write = 1'b0;
	logic reg_addrvalid = 1'b0;
	logic [5:0] reg_hypaddress = '0;
	logic fpa_in = 1'b0;
	logic fpb_in = 1'b0;
	logic [3:0] rear_in = '0;
	logic trig_advio = 1'b0;
	logic trig_ana = 1'b0;
	logic trig_dec = 1'b0;
	logic uart_tx = 1'b1;
	logic usi_out = 1'b1;
	logic [3:0] targetio_in = '0;
	wire [7:0] reg_datao;
	wire [15:0] reg_hyplen;
	wire trigger;
	wire trigger_ext;
	pin_drive_t fpa;
	pin_drive_t fpb;
	pin_drive_t [3:0] targetio;
	wire uart_rx;
	wire usi_in;
	pin_drive_t nrst;
	pin_drive_t pdid;
	pin_drive_t pdic;
	wire targetpower_off;
	wire enable_avrprog;

	reg_row_t reg_tab [REG_ROWS];
	io_row_t io_tab [IO_ROWS];
	logic [7:0] io_data [8] = '{8'h31, 8'h42, 8'h53, 8'h64, 8'h75, 8'h01, 8'h97, 8'ha8};
	logic [31:0] seed = 32'd17004;
	int errors = 0;
	int checks = 0;

	cw_aux_io #(
		.PWM_BITS     (PWM_BITS),
		.PWM_ON_COUNT (PWM_ON_COUNT),
		.SOFT_PERIODS (SOFT_PERIODS)
	) u_cw_aux_io (
		.clk (clk), .reset (reset),
		.reg_address_i (reg_address), .reg_bytecnt_i (reg_bytecnt),
		.reg_datai_i (reg_datai), .reg_read_i (reg_read), .reg_write_i (reg_write),
		.reg_addrvalid_i (reg_addrvalid), .reg_hypaddress_i (reg_hypaddress),
		.reg_datao_o (reg_datao), .reg_hyplen_o (reg_hyplen),
		.fpa_in_i (fpa_in), .fpb_in_i (fpb_in), .rear_in_i (rear_in),
		.trigger_advio_i (trig_advio), .trigger_anapattern_i (trig_ana),
		.trigger_decodedio_i (trig_dec), .trigger_o (trigger), .trigger_ext_o (trigger_ext),
		.fpa_o (fpa), .fpb_o (fpb),
		.uart_tx_i (uart_tx), .usi_out_i (usi_out), .targetio_in_i (targetio_in),
		.targetio_o (targetio), .uart_rx_o (uart_rx), .usi_in_o (usi_in),
		.nrst_o (nrst), .pdid_o (pdid), .pdic_o (pdic),
		.targetpower_off_o (targetpower_off), .enable_avrprog_o (enable_avrprog)
	);

	always #(PERIOD / 2) clk = ~clk;

	initial begin
		#(LIMIT);
		$display("timeout: the run did not finish within %0d time units", LIMIT);
		$display("Test failed");
		$finish;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("test %s: %s", name, (errors == errors_before) ? "passed" : "failed");
	endtask

	task automatic reg_write_byte(input logic [5:0] addr, input logic [15:0] bc,
			input logic [7:0] data);
		reg_address   = addr; // data lands at the next rising edge
		reg_bytecnt   = bc;
		reg_datai     = data;
		reg_write     = 1'b1;
		reg_addrvalid = 1'b1;
		@(negedge clk);
		reg_write     = 1'b0;
		reg_addrvalid = 1'b0;
	endtask

	task automatic reg_read_check(input logic [5:0] addr, input logic [15:0] bc,
			input logic [7:0] exp);
		reg_address   = addr;
		reg_bytecnt   = bc;
		reg_read      = 1'b1;
		reg_addrvalid = 1'b1;
		@(negedge clk);
		reg_read      = 1'b0;
		reg_addrvalid = 1'b0;
		check_value($sformatf("read addr %0d byte %0d", addr, bc), 16'(reg_datao), 16'(exp));
	endtask

	function automatic reg_row_t reg_row(input logic [1:0] k, input logic [5:0] a,
			input logic [15:0] bc, input logic [7:0] d);
		return '{kind: k, addr: a, bytecnt: bc, data: d};
	endfunction

	function automatic io_row_t io_row(input logic [2:0] b, input logic [7:0] d,
			input logic tx, input logic usi, input logic [3:0] tin, input logic [7:0] pins,
			input logic rx, input logic ui);
		return '{byte_i: b, data: d, tx: tx, usi: usi, tin: tin, pins: pins, rx: rx, usi_in: ui};
	endfunction

	task automatic fill_tables();
		reg_tab[0] = reg_row(K_RD, 6'd39, 16'd0, 8'h01); // reset values
		reg_tab[1] = reg_row(K_RD, 6'd40, 16'd0, 8'h00);
		reg_tab[2] = reg_row(K_RD, 6'd55, 16'd0, 8'h01);
		reg_tab[3] = reg_row(K_RD, 6'd55, 16'd1, 8'h02);
		reg_tab[4] = reg_row(K_RD, 6'd55, 16'd5, 8'h00);
		reg_tab[5] = reg_row(K_LEN, 6'd39, 16'd0, 8'd1);
		reg_tab[6] = reg_row(K_LEN, 6'd40, 16'd0, 8'd1);
		reg_tab[7] = reg_row(K_LEN, 6'd55, 16'd0, 8'd8);
		reg_tab[8] = reg_row(K_LEN, 6'd0, 16'd0, 8'd0);
		reg_tab[9] = reg_row(K_LEN, 6'd41, 16'd0, 8'd0);
		reg_tab[10] = reg_row(K_WR, 6'd39, 16'd0, 8'hb6);
		reg_tab[11] = reg_row(K_RD, 6'd39, 16'd0, 8'hb6);
		reg_tab[12] = reg_row(K_WR, 6'd40, 16'd0, 8'h1d);
		reg_tab[13] = reg_row(K_RD, 6'd40, 16'd0, 8'h1d);
		for (int b = 0; b < 8; b++) begin
			reg_tab[14 + b] = reg_row(K_WR, 6'd55, 16'(b), io_data[b]);
			reg_tab[22 + b] = reg_row(K_RD, 6'd55, 16'(b), io_data[b]);
		end
		reg_tab[30] = reg_row(K_RD, 6'd12, 16'd0, 8'h00); // unmapped reads zero
		io_tab[0]  = io_row(3'd0, 8'h01, 1'b0, 1'b1, 4'b1010, 8'h01, 1'b1, 1'b1); // pin 1 tx
		io_tab[1]  = io_row(3'd1, 8'h02, 1'b1, 1'b0, 4'b0000, 8'h03, 1'b0, 1'b1); // pin 2 rx
		io_tab[2]  = io_row(3'd3, 8'h02, 1'b1, 1'b0, 4'b1000, 8'h03, 1'b0, 1'b1); // lowest rx wins
		io_tab[3]  = io_row(3'd1, 8'h00, 1'b1, 1'b0, 4'b0000, 8'h03, 1'b0, 1'b1);
		io_tab[4]  = io_row(3'd2, 8'h05, 1'b0, 1'b1, 4'b0000, 8'h11, 1'b0, 1'b1); // tx over usi
		io_tab[5]  = io_row(3'd2, 8'h14, 1'b0, 1'b1, 4'b0000, 8'h31, 1'b0, 1'b1); // usi over oc
		io_tab[6]  = io_row(3'd2, 8'h90, 1'b0, 1'b1, 4'b0000, 8'h01, 1'b0, 1'b1); // oc released
		io_tab[7]  = io_row(3'd2, 8'h90, 1'b0, 1'b0, 4'b0000, 8'h11, 1'b0, 1'b1); // oc pulls low
		io_tab[8]  = io_row(3'd2, 8'h20, 1'b1, 1'b0, 4'b0000, 8'h03, 1'b0, 1'b1);
		io_tab[9]  = io_row(3'd2, 8'h20, 1'b0, 1'b0, 4'b0000, 8'h11, 1'b0, 1'b1);
		io_tab[10] = io_row(3'd3, 8'hc0, 1'b0, 1'b0, 4'b0000, 8'hd1, 1'b1, 1'b1); // manual high
		io_tab[11] = io_row(3'd3, 8'h04, 1'b0, 1'b1, 4'b0000, 8'h11, 1'b1, 1'b1); // no usi on pin 4
		io_tab[12] = io_row(3'd0, 8'h08, 1'b1, 1'b1, 4'b0110, 8'h00, 1'b1, 1'b0);
		io_tab[13] = io_row(3'd1, 8'h08, 1'b1, 1'b1, 4'b0110, 8'h00, 1'b1, 1'b0);
		io_tab[14] = io_row(3'd0, 8'h00, 1'b1, 1'b1, 4'b0101, 8'h00, 1'b1, 1'b0);
	endtask

	task automatic trigger_test();
		logic [7:0] src;
		logic [7:0] mod;
		logic [5:0] vals;
		logic any_hi;
		logic all_hi;
		logic ext;
		logic trig;
		for (int i = 0; i < TRIG_ITERS; i++) begin
			seed = lcg_next(seed);
			src  = {i[1:0], seed[21:16]};          // every mode, random enables
			mod  = {3'b000, seed[23:22], i[4:2]};  // every module code
			reg_write_byte(6'd39, 16'd0, src);
			reg_write_byte(6'd40, 16'd0, mod);
			for (int p = 0; p < 3; p++) begin
				seed = lcg_next(seed);
				{rear_in, fpb_in, fpa_in} = seed[21:16];
				{trig_advio, trig_ana, trig_dec} = seed[26:24];
				vals   = seed[21:16];
				any_hi = 1'b0;
				all_hi = 1'b1;
				for (int k = 0; k < 6; k++) begin
					if (src[k]) begin
						any_hi = any_hi | vals[k];
						all_hi = all_hi & vals[k];
					end
				end
				ext  = (src[7:6] == 2'd0) ? any_hi : (src[7:6] == 2'd1) ? all_hi :
						(src[7:6] == 2'd2) ? ~all_hi : 1'b0;
				trig = (mod[2:0] == 3'd0) ? ext : (mod[2:0] == 3'd1) ? trig_advio :
						(mod[2:0] == 3'd2) ? trig_ana : (mod[2:0] == 3'd3) ? trig_dec : 1'b0;
				#1;
				check_value("trigger_ext", 16'(trigger_ext), 16'(ext));
				check_value("trigger", 16'(trigger), 16'(trig));
				check_value("fpa drive", 16'(fpa), 16'({trig & mod[3], mod[3]}));
				check_value("fpb drive", 16'(fpb), 16'({trig & mod[4], mod[4]}));
				@(negedge clk);
			end
		end
	endtask

	task automatic power_test();
		int highs;
		int guard;
		reg_write_byte(6'd55, 16'd0, 8'h01); // pin 1 carries tx
		uart_tx = 1'b1;
		reg_write_byte(6'd55, 16'd5, 8'h02);
		repeat (2) @(negedge clk);
		check_value("power off switch", 16'(targetpower_off), 16'd1);
		check_value("pins released", 16'(targetio & 8'h55), 16'd0);
		reg_write_byte(6'd55, 16'd5, 8'h04); // fast start
		check_value("fast start same cycle", 16'(targetpower_off), 16'd1);
		@(negedge clk);
		check_value("fast start one cycle", 16'(targetpower_off), 16'd0);
		highs = 0;
		repeat (40) begin
			@(negedge clk);
			highs += int'(targetpower_off);
		end
		check_value("fast start pulses", 16'(highs), 16'd0);
		reg_write_byte(6'd55, 16'd5, 8'h02);
		repeat (3) @(negedge clk);
		check_value("power off again", 16'(targetpower_off), 16'd1);
		reg_write_byte(6'd55, 16'd5, 8'h00); // slow start
		guard = 0;
		while (targetpower_off && guard < 8) begin
			@(negedge clk);
			guard++;
		end
		if (targetpower_off) begin
			$display("power switch never turned on after power off was cleared");
			errors++;
		end
		highs = 0;
		repeat (SOFT_LEN) begin
			@(negedge clk);
			highs += int'(targetpower_off);
		end
		check_value("soft-start pulses", 16'(highs), 16'(SOFT_PERIODS * PWM_ON_COUNT));
		highs = 0;
		repeat (2 << PWM_BITS) begin
			@(negedge clk);
			highs += int'(targetpower_off);
		end
		check_value("on after soft-start", 16'(highs), 16'd0);
	endtask

	initial begin
		int mark;
		fill_tables();
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		mark = errors;
		for (int r = 0; r < REG_ROWS; r++) begin
			case (reg_tab[r].kind)
				K_WR: reg_write_byte(reg_tab[r].addr, reg_tab[r].bytecnt, reg_tab[r].data);
				K_RD: reg_read_check(reg_tab[r].addr, reg_tab[r].bytecnt, reg_tab[r].data);
				default: begin
					reg_hypaddress = reg_tab[r].addr;
					#1;
					check_value($sformatf("length of %0d", reg_tab[r].addr), reg_hyplen,
							16'(reg_tab[r].data));
					@(negedge clk);
				end
			endcase
		end
		check_value("avr programming enable", 16'(enable_avrprog), 16'd1); // byte 5 bit 0 set
		report_test("register map", mark);
		mark = errors;
		trigger_test();
		report_test("trigger combine", mark);
		mark = errors;
		for (int b = 0; b < 8; b++)
			reg_write_byte(6'd55, 16'(b), 8'h00); // clean routing state
		check_value("avr programming released", 16'(enable_avrprog), 16'd0);
		for (int r = 0; r < IO_ROWS; r++) begin
			reg_write_byte(6'd55, 16'(io_tab[r].byte_i), io_tab[r].data);
			uart_tx     = io_tab[r].tx;
			usi_out     = io_tab[r].usi;
			targetio_in = io_tab[r].tin;
			#1;
			check_value($sformatf("io row %0d pins", r), 16'(targetio), 16'(io_tab[r].pins));
			check_value($sformatf("io row %0d rx", r), 16'(uart_rx), 16'(io_tab[r].rx));
			check_value($sformatf("io row %0d usi in", r), 16'(usi_in), 16'(io_tab[r].usi_in));
		end
		reg_write_byte(6'd55, 16'd6, 8'h2d);
		check_value("extra gpio", 16'({nrst, pdid, pdic}), 16'(6'b01_11_10));
		report_test("target io", mark);
		mark = errors;
		power_test();
		report_test("target power", mark);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: cw_aux_io.f
source/cw_route_pkg.sv
source/cw_reg_map_pkg.sv
source/cw_config_regs.sv
source/cw_trigger_mux.sv
source/cw_target_io.sv
source/cw_target_power.sv
source/cw_aux_io.sv
sim/cw_aux_io_assertions.sv
sim/cw_aux_io_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= cw_aux_io.f
TB_TOP    ?= cw_aux_io_tb
RTL_TOP   ?= cw_aux_io
BUILD_DIR ?= obj_dir
RTL_SRCS  ?= source/cw_route_pkg.sv source/cw_reg_map_pkg.sv source/cw_config_regs.sv \
             source/cw_trigger_mux.sv source/cw_target_io.sv source/cw_target_power.sv \
             source/cw_aux_io.sv
PASS_MSG  ?= Test completed successfully
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TB_TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
